// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int WORD_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] beat_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [WORD_W-1:0] word_t;

  // Access size field of funct3.
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef struct packed {
    logic       uns;  // Zero extend on load.
    logic [1:0] size;
  } width_fields_t;

  typedef union packed {
    logic [2:0]    raw;  // RV32 funct3 as encoded.
    width_fields_t f;
  } width_code_u;

  typedef logic [1:0] resp_t;
  localparam resp_t OKAY   = 2'b00;
  localparam resp_t SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== lsu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lsu_bus_if;
  import lsu_pkg::*;

  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  beat_t wdata, rdata;
  strb_t wstrb;
  resp_t bresp, rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rresp, rdata
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rresp, rdata
  );
endinterface

`default_nettype wire

// ==== lsu_agu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  lsu_pkg::addr_t       base,
  input  lsu_pkg::addr_t       offset,
  input  lsu_pkg::word_t       store_data,
  input  logic                 is_store,
  input  lsu_pkg::width_code_u funct3,
  input  logic                 busy,
  output logic                 issue,
  output logic                 misalign,
  output lsu_pkg::addr_t       addr,
  output lsu_pkg::strb_t       strb,
  output lsu_pkg::beat_t       wbeat,
  output logic                 write,
  output logic [2:0]           lane,
  output lsu_pkg::width_code_u code
);
  import lsu_pkg::*;

  addr_t eff_addr;
  logic  accept;
  logic  bad_align;
  strb_t size_mask;
  beat_t rep_data;

  assign accept   = start && !busy;  // Starts during an operation are dropped.
  assign eff_addr = base + offset;

  always_comb begin
    case (funct3.f.size)
      SIZE_BYTE: begin
        bad_align = 1'b0;
        size_mask = 8'h01;
        rep_data  = {8{store_data[7:0]}};
      end
      SIZE_HALF: begin
        bad_align = eff_addr[0];
        size_mask = 8'h03;
        rep_data  = {4{store_data[15:0]}};
      end
      default: begin
        bad_align = |eff_addr[1:0];  // Word needs a multiple of four.
        size_mask = 8'h0f;
        rep_data  = {2{store_data}};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue    <= 1'b0;
      misalign <= 1'b0;
    end else begin
      issue    <= accept && !bad_align;
      misalign <= accept && bad_align;
    end
  end

  // Operation payload held for the whole access.
  always_ff @(posedge clk) begin
    if (accept) begin
      addr  <= eff_addr;
      strb  <= size_mask << eff_addr[2:0];
      wbeat <= rep_data;
      write <= is_store;
      lane  <= eff_addr[2:0];
      code  <= funct3;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_axi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_master (
  input  logic           clk,
  input  logic           rst,
  input  logic           issue,
  input  lsu_pkg::addr_t addr,
  input  lsu_pkg::strb_t strb,
  input  lsu_pkg::beat_t wbeat,
  input  logic           write,
  lsu_bus_if.master      bus,
  output logic           complete,
  output lsu_pkg::beat_t rbeat,
  output lsu_pkg::resp_t resp
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,  // Address (and write data) phase.
    S_DATA,  // Waiting for the read beat.
    S_RESP   // Waiting for the write response.
  } state_t;

  state_t state;
  addr_t  addr_q;
  strb_t  strb_q;
  beat_t  wbeat_q;
  logic   write_q;
  logic   arvalid_q;
  logic   rready_q;
  logic   awvalid_q;
  logic   wvalid_q;
  logic   bready_q;
  logic   aw_ok;
  logic   w_ok;

  assign bus.arvalid = arvalid_q;
  assign bus.rready  = rready_q;
  assign bus.awvalid = awvalid_q;
  assign bus.wvalid  = wvalid_q;
  assign bus.bready  = bready_q;
  assign bus.araddr  = addr_q;
  assign bus.awaddr  = addr_q;
  assign bus.wdata   = wbeat_q;
  assign bus.wstrb   = strb_q;

  // Each write channel is done once it has handshaken, now or earlier.
  assign aw_ok = !awvalid_q || bus.awready;
  assign w_ok  = !wvalid_q || bus.wready;

  always_ff @(posedge clk) begin
    if (state == S_IDLE && issue) begin
      addr_q  <= addr;
      strb_q  <= strb;
      wbeat_q <= wbeat;
      write_q <= write;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      bready_q  <= 1'b0;
      complete  <= 1'b0;
    end else begin
      complete <= 1'b0;
      case (state)
        S_IDLE: begin
          if (issue) begin
            arvalid_q <= !write;
            awvalid_q <= write;
            wvalid_q  <= write;
            state     <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (write_q) begin
            if (bus.awready) awvalid_q <= 1'b0;
            if (bus.wready) wvalid_q <= 1'b0;
            if (aw_ok && w_ok) begin
              bready_q <= 1'b1;
              state    <= S_RESP;
            end
          end else if (bus.arready) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b1;
            state     <= S_DATA;
          end
        end
        S_DATA: begin
          if (bus.rvalid) begin
            rready_q <= 1'b0;
            complete <= 1'b1;
            state    <= S_IDLE;
          end
        end
        S_RESP: begin
          if (bus.bvalid) begin
            bready_q <= 1'b0;
            complete <= 1'b1;  // Finish on B, not on W.
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && bus.rvalid && rready_q) begin
      rbeat <= bus.rdata;
      resp  <= bus.rresp;
    end else if (state == S_RESP && bus.bvalid && bready_q) begin
      resp <= bus.bresp;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue,
  input  logic                 complete,
  input  logic                 misalign,
  input  lsu_pkg::beat_t       rbeat,
  input  lsu_pkg::resp_t       resp,
  input  logic [2:0]           lane,
  input  lsu_pkg::width_code_u code,
  input  logic                 write,
  output lsu_pkg::word_t       load_data,
  output logic                 done,
  output logic                 err,
  output logic                 busy
);
  import lsu_pkg::*;

  beat_t shifted;
  word_t ext;
  logic  busy_q;

  assign shifted = rbeat >> {lane, 3'b000};  // Addressed item to bit 0.

  always_comb begin
    case (code.raw)
      3'b000:  ext = {{24{shifted[7]}}, shifted[7:0]};    // LB.
      3'b001:  ext = {{16{shifted[15]}}, shifted[15:0]};  // LH.
      3'b100:  ext = {24'b0, shifted[7:0]};               // LBU.
      3'b101:  ext = {16'b0, shifted[15:0]};              // LHU.
      default: ext = shifted[31:0];
    endcase
  end

  // Covers the issue cycle so a second start is refused right away.
  assign busy = busy_q || issue || misalign;

  always_ff @(posedge clk) begin
    if (rst) begin
      done      <= 1'b0;
      err       <= 1'b0;
      busy_q    <= 1'b0;
      load_data <= '0;
    end else begin
      done <= complete || misalign;
      if (complete || misalign) begin
        err <= misalign || (resp == SLVERR);
      end
      if (complete && !write) begin
        load_data <= ext;
      end
      if (complete) begin
        busy_q <= 1'b0;
      end else if (issue) begin
        busy_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== axi_lite_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ram #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic      clk,
  input  logic      rst,
  lsu_bus_if.slave  bus
);
  import lsu_pkg::*;

  localparam int DEPTH = 2 ** (MEM_ADDR_BITS - 3);  // One entry per 64-bit beat.

  beat_t                    mem [DEPTH];
  logic                     wr_fire;
  logic                     rd_fire;
  logic                     wr_in_range;
  logic                     rd_in_range;
  logic [MEM_ADDR_BITS-4:0] wr_idx;
  logic [MEM_ADDR_BITS-4:0] rd_idx;

  assign bus.awready = !bus.bvalid;
  assign bus.wready  = !bus.bvalid;
  assign bus.arready = !bus.rvalid;

  assign wr_fire     = bus.awvalid && bus.wvalid && !bus.bvalid;  // AW and W as a pair.
  assign rd_fire     = bus.arvalid && bus.arready;
  assign wr_in_range = (bus.awaddr >> MEM_ADDR_BITS) == '0;
  assign rd_in_range = (bus.araddr >> MEM_ADDR_BITS) == '0;
  assign wr_idx      = bus.awaddr[MEM_ADDR_BITS-1:3];
  assign rd_idx      = bus.araddr[MEM_ADDR_BITS-1:3];

  always_ff @(posedge clk) begin
    if (wr_fire && wr_in_range) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (bus.wstrb[i]) mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      bus.rdata <= rd_in_range ? mem[rd_idx] : '0;
      bus.rresp <= rd_in_range ? OKAY : SLVERR;
    end
    if (wr_fire) begin
      bus.bresp <= wr_in_range ? OKAY : SLVERR;  // Out of range writes are dropped.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.rvalid <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (rd_fire) bus.rvalid <= 1'b1;
      else if (bus.rready) bus.rvalid <= 1'b0;
      if (wr_fire) bus.bvalid <= 1'b1;
      else if (bus.bready) bus.bvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  lsu_pkg::addr_t       base,
  input  lsu_pkg::addr_t       offset,
  input  lsu_pkg::word_t       store_data,
  input  logic                 is_store,
  input  lsu_pkg::width_code_u funct3,
  output lsu_pkg::word_t       load_data,
  output logic                 done,
  output logic                 err,
  output logic                 busy
);
  import lsu_pkg::*;

  logic        issue;
  logic        misalign;
  addr_t       addr;
  strb_t       strb;
  beat_t       wbeat;
  logic        write;
  logic [2:0]  lane;
  width_code_u code;
  logic        complete;
  beat_t       rbeat;
  resp_t       resp;

  lsu_bus_if bus ();

  lsu_agu agu0 (
    .clk, .rst, .start, .base, .offset, .store_data, .is_store, .funct3, .busy,
    .issue, .misalign, .addr, .strb, .wbeat, .write, .lane, .code
  );

  lsu_axi_master master0 (
    .clk, .rst, .issue, .addr, .strb, .wbeat, .write,
    .bus (bus.master),
    .complete, .rbeat, .resp
  );

  lsu_load_align align0 (
    .clk, .rst, .issue, .complete, .misalign, .rbeat, .resp, .lane, .code, .write,
    .load_data, .done, .err, .busy
  );

  axi_lite_ram #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) ram0 (
    .clk, .rst,
    .bus (bus.slave)
  );

endmodule

`default_nettype wire

// ==== lsu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
  input logic           clk,
  input logic           rst,
  input logic           arvalid,
  input logic           arready,
  input lsu_pkg::addr_t araddr,
  input logic           awvalid,
  input logic           awready,
  input lsu_pkg::addr_t awaddr,
  input logic           wvalid,
  input logic           wready,
  input lsu_pkg::beat_t wdata,
  input lsu_pkg::strb_t wstrb,
  input logic           complete
);

  logic fired = 1'b0;  // Set by any failing assertion.

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("arvalid or araddr changed before arready");
      fired = 1'b1;
    end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("awvalid or awaddr changed before awready");
      fired = 1'b1;
    end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
      $error("wvalid, wdata or wstrb changed before wready");
      fired = 1'b1;
    end

  complete_pulse: assert property (@(posedge clk) disable iff (rst)
    complete |=> !complete)
    else begin
      $error("complete high in two consecutive cycles");
      fired = 1'b1;
    end

endmodule

bind lsu_axi_master lsu_sva sva0 (
  .clk, .rst,
  .arvalid (bus.arvalid),
  .arready (bus.arready),
  .araddr  (bus.araddr),
  .awvalid (bus.awvalid),
  .awready (bus.awready),
  .awaddr  (bus.awaddr),
  .wvalid  (bus.wvalid),
  .wready  (bus.wready),
  .wdata   (bus.wdata),
  .wstrb   (bus.wstrb),
  .complete
);

`default_nettype wire

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
  import lsu_pkg::*;

  localparam int MEM_ADDR_BITS = 10;  // DUT default.
  localparam int DONE_TIMEOUT  = 100;

  logic        clk = 1'b0;
  logic        rst;
  logic        start;
  addr_t       base;
  addr_t       offset;
  word_t       store_data;
  logic        is_store;
  width_code_u funct3;
  word_t       load_data;
  logic        done;
  logic        err;
  logic        busy;
  integer      seed = 46;

  lsu_top dut0 (
    .clk, .rst, .start, .base, .offset, .store_data, .is_store, .funct3,
    .load_data, .done, .err, .busy
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("ERROR: %s at time %0t", why, $time);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("ERROR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Misaligned for its size, or outside the RAM window.
  function automatic logic expected_error(input addr_t a, input width_code_u code);
    logic bad;
    case (code.f.size)
      SIZE_BYTE: bad = 1'b0;
      SIZE_HALF: bad = a[0];
      default:   bad = |a[1:0];
    endcase
    return bad || (a >= (addr_t'(1) << MEM_ADDR_BITS));
  endfunction

  task automatic run_operation(input logic st, input addr_t b, input addr_t o,
                               input word_t d, input width_code_u code, input logic dup);
    int   cycles;
    logic seen;
    is_store   = st;
    base       = b;
    offset     = o;
    store_data = d;
    funct3     = code;
    start      = 1'b1;
    @(negedge clk);
    check_bit("busy", 1'b1, busy);  // Accepted on the last rising edge.
    if (dup) begin
      base = addr_t'($random(seed));  // Second start while busy.
    end else begin
      start = 1'b0;
    end
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      start  = 1'b0;
      cycles = cycles + 1;
      seen   = done;
    end
    if (!seen) begin
      abort_run("done never arrived within 100 cycles");
    end
  endtask

  // One done per operation, and busy stays low while idle.
  task automatic check_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_bit("done", 1'b0, done);
      check_bit("busy", 1'b0, busy);
    end
  endtask

  always @(negedge clk) begin
    if (dut0.master0.sva0.fired === 1'b1) begin
      abort_run("a bus handshake assertion failed");
    end
  end

  initial begin
    int          fd;
    int          n;
    int          line_no;
    int          ops;
    string       line;
    logic [31:0] f_store, f_base, f_off, f_data, f_code, f_load, f_err;
    width_code_u code;
    logic        dup;
    rst        = 1'b1;
    start      = 1'b0;
    base       = '0;
    offset     = '0;
    store_data = '0;
    is_store   = 1'b0;
    funct3     = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
    check_bit("err", 1'b0, err);
    fd = $fopen("lsu_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open lsu_testdata.txt");
    end
    line_no = 0;
    ops     = 0;
    while (!$feof(fd)) begin
      n       = $fgets(line, fd);
      line_no = line_no + 1;
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  f_store, f_base, f_off, f_data, f_code, f_load, f_err);
      if (n != 7) begin
        abort_run($sformatf("line %0d of the test data is malformed", line_no));
      end
      code.raw = f_code[2:0];
      if (expected_error(f_base + f_off, code) !== f_err[0]) begin
        abort_run($sformatf("line %0d expects an err that breaks the access rules", line_no));
      end
      dup = ($random(seed) & 1) != 0;
      run_operation(f_store[0], f_base, f_off, f_data, code, dup);
      check_bit("err", f_err[0], err);
      check_word("load_data", f_load, load_data);  // Held value after stores.
      check_quiet(3);
      ops = ops + 1;
    end
    $fclose(fd);
    if (ops == 0) begin
      abort_run("the test data holds no operations");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_testdata.txt ====
# Columns in hex: is_store base offset store_data funct3 expected_load_data expected_err
# Stores and refused loads expect load_data to hold its previous value.
1 00000100 00000000 deadbeef 2 00000000 0
0 00000100 00000000 00000000 2 deadbeef 0
1 00000100 00000008 11223344 2 deadbeef 0
1 00000108 00000004 55667788 2 deadbeef 0
1 00000100 00000009 ffffffa5 0 deadbeef 0
1 00000100 0000000e 12348001 1 deadbeef 0
0 00000100 00000008 00000000 2 1122a544 0
0 0000010c 00000000 00000000 2 80017788 0
0 00000100 00000009 00000000 0 ffffffa5 0
0 00000100 00000009 00000000 4 000000a5 0
0 00000100 0000000e 00000000 1 ffff8001 0
0 00000100 0000000e 00000000 5 00008001 0
1 00000100 00000003 0000ffff 1 00008001 1
0 00000100 00000002 00000000 2 00008001 1
0 00000100 00000000 00000000 2 deadbeef 0
1 00000400 00000000 cafef00d 2 deadbeef 1
0 000003fc 00000008 00000000 2 00000000 1

// ==== all.f ====
lsu_pkg.sv
lsu_bus_if.sv
lsu_agu.sv
lsu_axi_master.sv
lsu_load_align.sv
axi_lite_ram.sv
lsu_top.sv
lsu_sva.sv
tb_lsu.sv

// ==== Makefile ====
SOURCES = $(wildcard *.sv)

all: run

obj_dir/Vtb_lsu: all.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_lsu -f all.f -o Vtb_lsu

run: obj_dir/Vtb_lsu lsu_testdata.txt
	obj_dir/Vtb_lsu +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
